/* Makefile */
# Verilator build and run for the KW4281 display driver

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_kw4281_display
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := All checks passed

SOURCES := $(wildcard verilog/*.sv verilog/*.svh tb/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides pass or fail
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
	  echo "simulation ok"; \
	else \
	  echo "simulation did not pass"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* compile.f */
+incdir+verilog
verilog/kw4281_pkg.sv
verilog/bin_to_digits.sv
verilog/display_scan.sv
verilog/kw4281_display_top.sv
tb/tb_kw4281_display.sv

/* tb/tb_kw4281_display.sv */
`timescale 1ns/100ps
`include "kw4281_cfg.svh"

module tb_kw4281_display;

  import kw4281_pkg::*;

  // ----------------------------------------------------------------------
  // timing
  // ----------------------------------------------------------------------

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 10;
  localparam int DWELL        = `KW4281_DWELL_CYCLES;
  localparam int FRAME        = 4 * DWELL;
  // two frames plus a spare dwell at each end for cut-off runs
  localparam int CAPTURE      = 2 * FRAME + 2 * DWELL;
  // converter needs at most 14 cycles
  localparam int DONE_WAIT    = 20;

  // one row of the stimulus table
  typedef struct {
    string name;
    int    value;
    int    bright;
    bit    has_second;
    int    second;
  } test_entry_t;

  logic                        clk_1000hz;
  logic                        rst_i;
  logic signed [7:0]           value_i;
  logic                        load_i;
  logic [`KW4281_BRIGHT_W-1:0] brightness_i;
  logic [3:0]                  an_o;
  logic [6:0]                  seg_o;
  logic                        digits_valid_o;

  test_entry_t table_q[$];
  logic [31:0] rng_state;
  int          error_count = 0;
  int          fail_tests = 0;
  int          valid_count = 0;
  bit          table_ready = 1'b0;
  // samples of one capture window
  logic [3:0]  an_cap[CAPTURE];
  seg_t        seg_cap[CAPTURE];

  kw4281_display_top kw4281_display_top_inst (
    .clk_1000hz     (clk_1000hz),
    .rst_i          (rst_i),
    .value_i        (value_i),
    .load_i         (load_i),
    .brightness_i   (brightness_i),
    .an_o           (an_o),
    .seg_o          (seg_o),
    .digits_valid_o (digits_valid_o)
  );

  initial begin
    clk_1000hz = 1'b0;
    forever #(CLK_PERIOD / 2) clk_1000hz = ~clk_1000hz;
  end

  // finished conversions, counted mid-cycle
  always @(negedge clk_1000hz) begin
    if (digits_valid_o === 1'b1) begin
      valid_count++;
    end
  end

  // ----------------------------------------------------------------------
  // reference model
  // ----------------------------------------------------------------------

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // sign, hundreds, tens, units with leading zeros dark
  function automatic digit_array_t decimal_codes(input int value);
    int           mag;
    int           hund;
    int           tens;
    int           units;
    digit_array_t codes;
    mag      = (value < 0) ? -value : value;
    hund     = mag / 100;
    tens     = (mag / 10) % 10;
    units    = mag % 10;
    codes[3] = (value < 0) ? DIGIT_MINUS : DIGIT_BLANK;
    codes[2] = (hund == 0) ? DIGIT_BLANK : digit_code_t'(hund[3:0]);
    codes[1] = (hund == 0 && tens == 0) ? DIGIT_BLANK : digit_code_t'(tens[3:0]);
    codes[0] = digit_code_t'(units[3:0]);
    return codes;
  endfunction

  // lit segments as {g..a}, then inverted for the common anode
  function automatic seg_t seg_pattern(input digit_code_t code);
    logic [6:0] lit;
    case (code)
      DIGIT_0:     lit = 7'h3F;
      DIGIT_1:     lit = 7'h06;
      DIGIT_2:     lit = 7'h5B;
      DIGIT_3:     lit = 7'h4F;
      DIGIT_4:     lit = 7'h66;
      DIGIT_5:     lit = 7'h6D;
      DIGIT_6:     lit = 7'h7D;
      DIGIT_7:     lit = 7'h07;
      DIGIT_8:     lit = 7'h7F;
      DIGIT_9:     lit = 7'h6F;
      DIGIT_MINUS: lit = 7'h40;
      default:     lit = 7'h00;
    endcase
    return ~lit;
  endfunction

  // ----------------------------------------------------------------------
  // stimulus table
  // ----------------------------------------------------------------------

  task automatic add_entry(input string name, input int value, input int bright,
                           input bit has_second, input int second);
    test_entry_t e;
    e.name       = name;
    e.value      = value;
    e.bright     = bright;
    e.has_second = has_second;
    e.second     = second;
    table_q.push_back(e);
  endtask

  task automatic build_table();
    add_entry("zero", 0, 3, 1'b0, 0);
    add_entry("five", 5, 0, 1'b0, 0);
    add_entry("forty_two", 42, 1, 1'b0, 0);
    add_entry("hundred", 100, 2, 1'b0, 0);
    add_entry("max_pos", 127, 3, 1'b0, 0);
    add_entry("minus_one", -1, 2, 1'b0, 0);
    add_entry("minus_seven", -7, 1, 1'b0, 0);
    add_entry("minus_ninety", -90, 0, 1'b0, 0);
    add_entry("min_neg", -128, 3, 1'b0, 0);
    // second value lands while the first is still converting
    add_entry("restart_a", 99, 2, 1'b1, -56);
    add_entry("restart_b", -128, 1, 1'b1, 3);
    for (int i = 0; i < 8; i++) begin
      rng_state = xorshift32(rng_state);
      add_entry($sformatf("random_%0d", i), int'($signed(rng_state[7:0])),
                int'(rng_state[15:8]) % (1 << `KW4281_BRIGHT_W), 1'b0, 0);
    end
  endtask

  // ----------------------------------------------------------------------
  // drive and sample
  // ----------------------------------------------------------------------

  task automatic next_drive();
    @(posedge clk_1000hz);
    #1;
  endtask

  // one-cycle load strobe
  task automatic load_value(input int value, input int bright);
    value_i      = value[7:0];
    brightness_i = bright[`KW4281_BRIGHT_W-1:0];
    load_i       = 1'b1;
    next_drive();
    load_i = 1'b0;
  endtask

  task automatic wait_valid(input string name);
    int waited;
    bit seen;
    waited = 0;
    seen   = 1'b0;
    while (!seen && waited < DONE_WAIT) begin
      @(negedge clk_1000hz);
      seen = (digits_valid_o === 1'b1);
      waited++;
    end
    assert (seen) else begin
      $display("%s: digits_valid_o did not arrive within %0d cycles", name, DONE_WAIT);
      error_count++;
    end
  endtask

  task automatic capture_frames();
    for (int i = 0; i < CAPTURE; i++) begin
      @(negedge clk_1000hz);
      an_cap[i]  = an_o;
      seg_cap[i] = seg_o;
    end
  endtask

  task automatic check_dark(input int cycles);
    repeat (cycles) begin
      @(negedge clk_1000hz);
      assert (an_o === 4'b1111 && seg_o === SEG_BLANK && digits_valid_o === 1'b0) else begin
        $display("[ERROR] reset: expected an %b seg %b valid %b, actual an %b seg %b valid %b",
                 4'b1111, SEG_BLANK, 1'b0, an_o, seg_o, digits_valid_o);
        error_count++;
      end
    end
  endtask

  // ----------------------------------------------------------------------
  // frame checks
  // ----------------------------------------------------------------------

  task automatic check_frames(input string name, input int value, input int bright);
    digit_array_t codes;
    seg_t         want;
    logic [3:0]   seen;
    int           low_count;
    int           pos;
    int           run_pos;
    int           run_len;
    int           run_start;
    int           prev_pos;
    int           runs;
    int           want_len;
    codes     = decimal_codes(value);
    // lit while dwell count <= brightness, never past the dwell
    want_len  = (bright + 1 < DWELL) ? bright + 1 : DWELL;
    seen      = 4'b0000;
    run_pos   = -1;
    run_len   = 0;
    run_start = 0;
    prev_pos  = -1;
    runs      = 0;
    // one extra pass closes the last run
    for (int i = 0; i <= CAPTURE; i++) begin
      pos = -1;
      if (i < CAPTURE) begin
        low_count = 0;
        for (int p = 0; p < 4; p++) begin
          if (an_cap[i][p] == 1'b0) begin
            low_count++;
            pos = p;
          end
        end
        assert (low_count <= 1) else begin
          $display("%s: %0d anodes low at once in cycle %0d", name, low_count, i);
          error_count++;
        end
        if (pos >= 0) begin
          want      = seg_pattern(codes[pos]);
          seen[pos] = 1'b1;
          assert (seg_cap[i] === want) else begin
            $display("[ERROR] %s: digit %0d expected %b actual %b",
                     name, pos, want, seg_cap[i]);
            error_count++;
          end
        end
      end
      // run ends when the anode goes dark or moves on
      if (pos != run_pos) begin
        // runs cut by the window edges are skipped
        if (run_pos >= 0 && run_start > 0 && i < CAPTURE) begin
          runs++;
          assert (run_len == want_len) else begin
            $display("[ERROR] %s: lit cycles of digit %0d expected %0d actual %0d",
                     name, run_pos, want_len, run_len);
            error_count++;
          end
          // scan steps 3, 2, 1, 0
          if (prev_pos >= 0) begin
            assert (run_pos == (prev_pos + 3) % 4) else begin
              $display("[ERROR] %s: scan position expected %0d actual %0d",
                       name, (prev_pos + 3) % 4, run_pos);
              error_count++;
            end
          end
          prev_pos = run_pos;
        end
        run_pos   = pos;
        run_len   = (pos >= 0) ? 1 : 0;
        run_start = i;
      end else if (pos >= 0) begin
        run_len++;
      end
    end
    assert (seen == 4'b1111) else begin
      $display("%s: not every digit position was lit during the capture", name);
      error_count++;
    end
    assert (runs >= 8) else begin
      $display("[ERROR] %s: complete dwells expected 8 actual %0d", name, runs);
      error_count++;
    end
  endtask

  task automatic run_test(input test_entry_t e);
    int errors_before;
    int valid_before;
    int shown;
    errors_before = error_count;
    valid_before  = valid_count;
    load_value(e.value, e.bright);
    if (e.has_second) begin
      // sampled two cycles after the first load
      next_drive();
      load_value(e.second, e.bright);
    end
    shown = e.has_second ? e.second : e.value;
    wait_valid(e.name);
    capture_frames();
    next_drive();
    assert (valid_count - valid_before == 1) else begin
      $display("[ERROR] %s: digits_valid_o pulses expected 1 actual %0d",
               e.name, valid_count - valid_before);
      error_count++;
    end
    check_frames(e.name, shown, e.bright);
    if (error_count == errors_before) begin
      $display("test %s: ok", e.name);
    end else begin
      $display("test %s: FAILED with %0d errors", e.name, error_count - errors_before);
      fail_tests++;
    end
  endtask

  // ----------------------------------------------------------------------
  // main sequence and watchdog
  // ----------------------------------------------------------------------

  initial begin
    rst_i        = 1'b0;
    load_i       = 1'b0;
    value_i      = '0;
    brightness_i = '0;
    rng_state    = 32'd85917;
    build_table();
    table_ready = 1'b1;
    // reset spans ten rising edges, display stays dark
    check_dark(RESET_CYCLES - 1);
    next_drive();
    rst_i = 1'b1;
    // still dark until the first load
    check_dark(6);
    next_drive();
    if (error_count == 0) begin
      $display("test reset: ok");
    end else begin
      $display("test reset: FAILED with %0d errors", error_count);
      fail_tests++;
    end
    foreach (table_q[i]) begin
      run_test(table_q[i]);
    end
    $display("tests %0d, failed %0d, errors %0d", table_q.size() + 1, fail_tests, error_count);
    if (error_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  // limit scales with the table length
  initial begin
    longint limit_ns;
    wait (table_ready);
    limit_ns = longint'(table_q.size() * (14 + 2 * FRAME + 10) + 20) * CLK_PERIOD * 2;
    #(limit_ns);
    $display("timeout: the run did not finish within %0d ns", limit_ns);
    $display("Checks failed");
    $finish;
  end

endmodule

/* verilog/bin_to_digits.sv */
`timescale 1ns/100ps

module bin_to_digits (
  input  logic                     clk_1000hz,
  input  logic                     rst_i,
  input  logic signed [7:0]        value_i,
  input  logic                     load_i,
  output kw4281_pkg::digit_array_t digits_o,
  output logic                     done_o
);

  import kw4281_pkg::*;

  // ----------------------------------------------------------------------
  // declarations
  // ----------------------------------------------------------------------

  // idle -> hundreds -> tens -> finish -> idle
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_HUNDREDS,
    ST_TENS,
    ST_FINISH
  } conv_state_t;

  conv_state_t state_q;

  // sign of the captured value
  logic        neg_q;
  // magnitude left over after the subtractions so far
  logic [7:0]  rem_q;
  // digit counters
  logic [3:0]  hund_q;
  logic [3:0]  tens_q;

  // unsigned magnitude of the input
  logic [7:0]  mag;

  // codes built in the finish state
  digit_code_t sign_code;
  digit_code_t hund_code;
  digit_code_t tens_code;
  digit_code_t unit_code;

  // ----------------------------------------------------------------------
  // magnitude
  // ----------------------------------------------------------------------

  // -128 wraps back to 8'h80, read as 128 unsigned
  assign mag = value_i[7] ? $unsigned(-value_i) : $unsigned(value_i);

  // ----------------------------------------------------------------------
  // control FSM
  // ----------------------------------------------------------------------

  always_ff @(posedge clk_1000hz or negedge rst_i) begin
    if (!rst_i) begin
      state_q <= ST_IDLE;
      done_o  <= 1'b0;
    end else begin
      done_o <= 1'b0;
      // a load always wins and restarts the conversion
      if (load_i) begin
        state_q <= ST_HUNDREDS;
      end else begin
        case (state_q)
          ST_HUNDREDS: begin
            if (rem_q < 8'd100) begin
              state_q <= ST_TENS;
            end
          end
          ST_TENS: begin
            if (rem_q < 8'd10) begin
              state_q <= ST_FINISH;
            end
          end
          ST_FINISH: begin
            // digits_o is written on this same edge
            done_o  <= 1'b1;
            state_q <= ST_IDLE;
          end
          default: begin
            state_q <= ST_IDLE;
          end
        endcase
      end
    end
  end

  // ----------------------------------------------------------------------
  // digit codes with leading-zero blanking
  // ----------------------------------------------------------------------

  always_comb begin
    sign_code = neg_q ? DIGIT_MINUS : DIGIT_BLANK;
    // hundreds dark when zero
    hund_code = (hund_q == 4'd0) ? DIGIT_BLANK : digit_code_t'(hund_q);
    // tens dark only if hundreds is dark too
    if ((hund_q == 4'd0) && (tens_q == 4'd0)) begin
      tens_code = DIGIT_BLANK;
    end else begin
      tens_code = digit_code_t'(tens_q);
    end
    // remainder is below 10 by now, units always shown
    unit_code = digit_code_t'(rem_q[3:0]);
  end

  // ----------------------------------------------------------------------
  // datapath
  // ----------------------------------------------------------------------

  always_ff @(posedge clk_1000hz) begin
    if (load_i) begin
      neg_q  <= value_i[7];
      rem_q  <= mag;
      hund_q <= 4'd0;
      tens_q <= 4'd0;
    end else begin
      case (state_q)
        ST_HUNDREDS: begin
          // one hundred per cycle
          if (rem_q >= 8'd100) begin
            rem_q  <= rem_q - 8'd100;
            hund_q <= hund_q + 4'd1;
          end
        end
        ST_TENS: begin
          // one ten per cycle
          if (rem_q >= 8'd10) begin
            rem_q  <= rem_q - 8'd10;
            tens_q <= tens_q + 4'd1;
          end
        end
        ST_FINISH: begin
          digits_o[3] <= sign_code;
          digits_o[2] <= hund_code;
          digits_o[1] <= tens_code;
          digits_o[0] <= unit_code;
        end
        default: begin
          rem_q <= rem_q;
        end
      endcase
    end
  end

endmodule

/* verilog/display_scan.sv */
`timescale 1ns/100ps
`include "kw4281_cfg.svh"

module display_scan (
  input  logic                         clk_1000hz,
  input  logic                         rst_i,
  input  kw4281_pkg::digit_array_t     digits_i,
  input  logic                         update_i,
  input  logic [`KW4281_BRIGHT_W-1:0]  brightness_i,
  output logic [3:0]                   an_o,
  output kw4281_pkg::seg_t             seg_o
);

  import kw4281_pkg::*;

  // ----------------------------------------------------------------------
  // sizing
  // ----------------------------------------------------------------------

  // at least one bit even for a single-cycle dwell
  localparam int DWELL_W =
    (`KW4281_DWELL_CYCLES > 1) ? $clog2(`KW4281_DWELL_CYCLES) : 1;
  // common width for the brightness compare
  localparam int CMP_W =
    (DWELL_W > `KW4281_BRIGHT_W) ? DWELL_W : `KW4281_BRIGHT_W;
  // last count before the digit index steps
  localparam logic [DWELL_W-1:0] DWELL_LAST = DWELL_W'(`KW4281_DWELL_CYCLES - 1);

  // ----------------------------------------------------------------------
  // declarations
  // ----------------------------------------------------------------------

  // digits currently on the display
  digit_array_t       shown_q;
  digit_array_t       shown_d;
  // set by the first update, keeps the display dark before that
  logic               showing_q;
  logic               showing_d;

  // dwell and digit counters
  logic [DWELL_W-1:0] dwell_q;
  logic [DWELL_W-1:0] dwell_d;
  logic [1:0]         idx_q;
  logic [1:0]         idx_d;

  // brightness compare operands
  logic [CMP_W-1:0]   dwell_cmp;
  logic [CMP_W-1:0]   bright_cmp;
  logic               lit_d;

  // next output values
  logic [3:0]         an_d;
  seg_t               seg_d;

  // ----------------------------------------------------------------------
  // segment decode
  // ----------------------------------------------------------------------

  function automatic seg_t seg_of(input digit_code_t code);
    seg_t pat;
    case (code)
      DIGIT_0:     pat = 7'b1000000;
      DIGIT_1:     pat = 7'b1111001;
      DIGIT_2:     pat = 7'b0100100;
      DIGIT_3:     pat = 7'b0110000;
      DIGIT_4:     pat = 7'b0011001;
      DIGIT_5:     pat = 7'b0010010;
      DIGIT_6:     pat = 7'b0000010;
      DIGIT_7:     pat = 7'b1111000;
      DIGIT_8:     pat = 7'b0000000;
      DIGIT_9:     pat = 7'b0010000;
      // g only
      DIGIT_MINUS: pat = 7'b0111111;
      // blank and any unused code
      default:     pat = SEG_BLANK;
    endcase
    return pat;
  endfunction

  // ----------------------------------------------------------------------
  // next state
  // ----------------------------------------------------------------------

  always_comb begin
    // new digits take effect on the edge after update
    shown_d   = update_i ? digits_i : shown_q;
    showing_d = showing_q | update_i;

    // dwell wraps, then index steps 3, 2, 1, 0, 3
    if (dwell_q == DWELL_LAST) begin
      dwell_d = '0;
      idx_d   = idx_q - 2'd1;
    end else begin
      dwell_d = dwell_q + DWELL_W'(1);
      idx_d   = idx_q;
    end
  end

  // ----------------------------------------------------------------------
  // anode gating and segment pattern
  // ----------------------------------------------------------------------

  always_comb begin
    dwell_cmp  = CMP_W'(dwell_d);
    bright_cmp = CMP_W'(brightness_i);
    // lit for the first brightness_i+1 cycles of the dwell
    lit_d      = showing_d && (dwell_cmp <= bright_cmp);

    // one-hot, active low
    if (lit_d) begin
      an_d = ~(4'b0001 << idx_d);
    end else begin
      an_d = 4'b1111;
    end

    // segments follow the digit for the whole dwell
    seg_d = seg_of(shown_d[idx_d]);
  end

  // ----------------------------------------------------------------------
  // registers
  // ----------------------------------------------------------------------

  // outputs are taken from the next-state values
  // so they line up with the counters every cycle
  always_ff @(posedge clk_1000hz or negedge rst_i) begin
    if (!rst_i) begin
      shown_q   <= DIGITS_ALL_BLANK;
      showing_q <= 1'b0;
      dwell_q   <= '0;
      idx_q     <= 2'd3;
      an_o      <= 4'b1111;
      seg_o     <= SEG_BLANK;
    end else begin
      shown_q   <= shown_d;
      showing_q <= showing_d;
      dwell_q   <= dwell_d;
      idx_q     <= idx_d;
      an_o      <= an_d;
      seg_o     <= seg_d;
    end
  end

endmodule

/* verilog/kw4281_cfg.svh */
`ifndef KW4281_CFG_SVH
`define KW4281_CFG_SVH

// ----------------------------------------------------------------------
// display timing
// ----------------------------------------------------------------------

// clk_1000hz cycles each digit stays selected
// a full frame takes four of these
`define KW4281_DWELL_CYCLES 4

// ----------------------------------------------------------------------
// brightness control
// ----------------------------------------------------------------------

// width of the brightness input
// an anode is lit while the dwell count is at most this value
// so with a 4-cycle dwell, 2 bits cover 1/4 up to full on
`define KW4281_BRIGHT_W 2

`endif

/* verilog/kw4281_display_top.sv */
`timescale 1ns/100ps
`include "kw4281_cfg.svh"

module kw4281_display_top (
  input  logic                         clk_1000hz,
  input  logic                         rst_i,
  // value to show, captured on load_i
  input  logic signed [7:0]            value_i,
  input  logic                         load_i,
  // anode on-time share
  input  logic [`KW4281_BRIGHT_W-1:0]  brightness_i,
  // display lines, active low
  output logic [3:0]                   an_o,
  output logic [6:0]                   seg_o,
  // one cycle per finished conversion
  output logic                         digits_valid_o
);

  import kw4281_pkg::*;

  // ----------------------------------------------------------------------
  // converter to scanner
  // ----------------------------------------------------------------------

  // sign, hundreds, tens, units codes
  digit_array_t digits;
  // digits are stable while this is high
  logic         conv_done;

  // ----------------------------------------------------------------------
  // binary to decimal converter
  // ----------------------------------------------------------------------

  bin_to_digits bin_to_digits_inst (
    .clk_1000hz (clk_1000hz),
    .rst_i      (rst_i),
    .value_i    (value_i),
    .load_i     (load_i),
    .digits_o   (digits),
    .done_o     (conv_done)
  );

  // ----------------------------------------------------------------------
  // multiplexed display scan
  // ----------------------------------------------------------------------

  display_scan display_scan_inst (
    .clk_1000hz   (clk_1000hz),
    .rst_i        (rst_i),
    .digits_i     (digits),
    .update_i     (conv_done),
    .brightness_i (brightness_i),
    .an_o         (an_o),
    .seg_o        (seg_o)
  );

  // the scanner latches on the same strobe
  assign digits_valid_o = conv_done;

endmodule

/* verilog/kw4281_pkg.sv */
package kw4281_pkg;

  // ----------------------------------------------------------------------
  // digit codes
  // ----------------------------------------------------------------------

  // one code per display position
  // 0..9 map straight to decimal digits
  typedef enum logic [3:0] {
    DIGIT_0     = 4'd0,
    DIGIT_1     = 4'd1,
    DIGIT_2     = 4'd2,
    DIGIT_3     = 4'd3,
    DIGIT_4     = 4'd4,
    DIGIT_5     = 4'd5,
    DIGIT_6     = 4'd6,
    DIGIT_7     = 4'd7,
    DIGIT_8     = 4'd8,
    DIGIT_9     = 4'd9,
    // only segment g
    DIGIT_MINUS = 4'd10,
    // all segments dark
    DIGIT_BLANK = 4'd15
  } digit_code_t;

  // [3] is the leftmost (sign) position, [0] the units
  typedef digit_code_t [3:0] digit_array_t;

  // power-up contents of the display
  localparam digit_array_t DIGITS_ALL_BLANK = '{
    DIGIT_BLANK, DIGIT_BLANK, DIGIT_BLANK, DIGIT_BLANK
  };

  // ----------------------------------------------------------------------
  // segment patterns
  // ----------------------------------------------------------------------

  // {g, f, e, d, c, b, a}, active low
  typedef logic [6:0] seg_t;

  // every segment off
  localparam seg_t SEG_BLANK = 7'b1111111;

endpackage
